/* hw/cpu_pkg.sv */
package cpu_pkg;

    // memory map and sizes
    localparam logic [31:0] RESET_PC     = 32'h4000_0000;
    localparam int          ROM_AWIDTH   = 5;             // 32 words of bios
    localparam logic [11:0] CSR_ADDR     = 12'h51e;
    localparam logic [31:0] UART_TX_ADDR = 32'h8000_0008;
    localparam int          CLKS_PER_BIT = 8;             // short, for simulation

    // rv32i major opcodes that the core decodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_IO_REQ,   // req high, waiting for ack
        ST_IO_DONE   // req low, waiting for ack to drop
    } cpu_state_e;

    // decode result handed to the control fsm
    typedef struct packed {
        logic        rf_we;
        logic        csr_we;
        logic        io_store;
        logic        take_branch;
        logic [31:0] next_pc;      // branch or jump target
    } dec_ctrl_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_wr_t;

    // request side of the uart handshake
    typedef struct packed {
        logic       req;
        logic [7:0] data;
    } tx_hs_t;

endpackage

/* hw/baud_timer.sv */
`timescale 1ns/1ps

module baud_timer import cpu_pkg::*; (
    input  logic clk,
    input  logic arst_n_i,
    input  logic en_i,
    output logic tick_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [CNT_W-1:0] cnt_q;
    logic             wrap;

    assign wrap = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            cnt_q <= '0;
        else if (!en_i || wrap)
            cnt_q <= '0;        // restart each bit period
        else
            cnt_q <= cnt_q + 1'b1;
    end

    assign tick_o = en_i && wrap;

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import cpu_pkg::*; (
    input  logic   clk,
    input  logic   arst_n_i,
    input  tx_hs_t hs_i,
    output logic   ack_o,
    output logic   serial_o
);

    logic       busy_q;
    logic       ack_q;
    logic [3:0] bit_cnt_q;
    logic [9:0] shift_q;    // stop, data lsb first, start
    logic       bit_tick;

    baud_timer u_baud (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .en_i     (busy_q),
        .tick_o   (bit_tick)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            ack_q     <= 1'b0;
            bit_cnt_q <= '0;
        end else if (!busy_q && !ack_q && hs_i.req) begin
            busy_q    <= 1'b1;
            bit_cnt_q <= '0;
        end else if (busy_q && bit_tick) begin
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;
                ack_q  <= 1'b1;         // stop bit done
            end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else if (ack_q && !hs_i.req) begin
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && !ack_q && hs_i.req)
            shift_q <= {1'b1, hs_i.data, 1'b0};
        else if (busy_q && bit_tick)
            shift_q <= {1'b1, shift_q[9:1]};
    end

    assign ack_o    = ack_q;
    assign serial_o = busy_q ? shift_q[0] : 1'b1;   // idle high

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o,
    input  rf_wr_t      wr_i
);

    logic [31:0] regs_q [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end else if (wr_i.we && wr_i.waddr != 5'd0) begin
            regs_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 : regs_q[rs2_addr_i];

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    output logic [4:0]  rs1_addr_o,
    output logic [4:0]  rs2_addr_o,
    output rf_wr_t      rf_wr_o,
    input  logic        rf_wr_en_i,
    output dec_ctrl_t   ctrl_o,
    output logic [31:0] csr_wdata_o,
    output logic [7:0]  tx_byte_o
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] add_res;
    logic [31:0] sub_res;
    logic [31:0] st_addr;
    logic [31:0] pc_plus4;
    logic [31:0] wdata;

    // instruction fields
    assign opcode     = instr_i[6:0];
    assign rd         = instr_i[11:7];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    assign add_res  = rs1_data_i + ((opcode == OPC_OPIMM) ? imm_i : rs2_data_i);
    assign sub_res  = rs1_data_i - rs2_data_i;
    assign st_addr  = rs1_data_i + imm_s;
    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.next_pc = pc_i + imm_b;
        wdata          = '0;
        case (opcode)
            OPC_LUI: begin
                ctrl_o.rf_we = 1'b1;
                wdata        = imm_u;
            end
            OPC_OPIMM: begin
                if (funct3 == 3'b000) begin       // addi
                    ctrl_o.rf_we = 1'b1;
                    wdata        = add_res;
                end
            end
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    ctrl_o.rf_we = 1'b1;
                    wdata        = add_res;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    ctrl_o.rf_we = 1'b1;
                    wdata        = sub_res;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b001)             // bne only
                    ctrl_o.take_branch = (rs1_data_i != rs2_data_i);
            end
            OPC_JAL: begin
                ctrl_o.rf_we       = 1'b1;
                ctrl_o.take_branch = 1'b1;
                ctrl_o.next_pc     = pc_i + imm_j;
                wdata              = pc_plus4;    // link
            end
            OPC_STORE: begin
                if (funct3 == 3'b010)             // sw, uart only
                    ctrl_o.io_store = (st_addr == UART_TX_ADDR);
            end
            OPC_SYSTEM: begin
                // csrrw, old value is not returned to rd
                if (funct3 == 3'b001 && instr_i[31:20] == CSR_ADDR)
                    ctrl_o.csr_we = 1'b1;
            end
            default: ;                            // anything else is a nop
        endcase
    end

    assign rf_wr_o.we    = rf_wr_en_i;
    assign rf_wr_o.waddr = rd;
    assign rf_wr_o.wdata = wdata;
    assign csr_wdata_o   = rs1_data_i;
    assign tx_byte_o     = rs2_data_i[7:0];

endmodule

/* hw/cpu_ctrl_fsm.sv */
`timescale 1ns/1ps

module cpu_ctrl_fsm import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [31:0]           instr_i,
    input  dec_ctrl_t             ctrl_i,
    input  logic [31:0]           csr_wdata_i,
    input  logic [7:0]            tx_byte_i,
    input  logic                  tx_ack_i,
    output logic [ROM_AWIDTH-1:0] rom_addr_o,
    output logic [31:0]           instr_o,
    output logic [31:0]           pc_o,
    output logic                  rf_wr_en_o,
    output logic [31:0]           csr_o,
    output tx_hs_t                tx_o
);

    cpu_state_e  state_q, state_d;
    logic [31:0] pc_q;
    logic [31:0] ir_q;
    logic [31:0] csr_q;
    logic [7:0]  tx_data_q;
    logic        exec;

    assign exec = (state_q == ST_EXEC);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FETCH:   state_d = ST_DECODE;
            ST_DECODE:  state_d = ST_EXEC;
            ST_EXEC:    state_d = ctrl_i.io_store ? ST_IO_REQ : ST_FETCH;
            ST_IO_REQ: begin
                if (tx_ack_i)
                    state_d = ST_IO_DONE;   // frame sent, drop req
            end
            ST_IO_DONE: begin
                if (!tx_ack_i)
                    state_d = ST_FETCH;     // handshake closed
            end
            default:    state_d = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_FETCH;
            pc_q    <= RESET_PC;
            csr_q   <= '0;
        end else begin
            state_q <= state_d;
            if (exec) begin
                pc_q <= ctrl_i.take_branch ? ctrl_i.next_pc : pc_q + 32'd4;
                if (ctrl_i.csr_we)
                    csr_q <= csr_wdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_DECODE)
            ir_q <= instr_i;                // rom word valid in decode
        if (exec && ctrl_i.io_store)
            tx_data_q <= tx_byte_i;         // held for the whole req phase
    end

    assign rom_addr_o = pc_q[ROM_AWIDTH+1:2];
    assign instr_o    = ir_q;
    assign pc_o       = pc_q;
    assign rf_wr_en_o = exec && ctrl_i.rf_we;
    assign csr_o      = csr_q;
    assign tx_o.req   = (state_q == ST_IO_REQ);
    assign tx_o.data  = tx_data_q;

endmodule

/* hw/bios_rom.sv */
`timescale 1ns/1ps

module bios_rom import cpu_pkg::*; (
    input  logic                  clk,
    input  logic [ROM_AWIDTH-1:0] addr_i,
    output logic [31:0]           data_o
);

    logic [31:0] mem [0:2**ROM_AWIDTH-1];

    initial begin
        $readmemh("bios.hex", mem);
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        data_o <= mem[addr_i];
    end

endmodule

/* hw/riscv151.sv */
`timescale 1ns/1ps

module riscv151 import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    output logic        serial_tx_o,
    output logic [31:0] csr_o
);

    logic [ROM_AWIDTH-1:0] rom_addr;
    logic [31:0]           rom_data;
    logic [31:0]           instr;
    logic [31:0]           pc;
    dec_ctrl_t             ctrl;
    logic [31:0]           csr_wdata;
    logic [7:0]            tx_byte;
    logic                  tx_ack;
    tx_hs_t                tx_hs;
    logic                  rf_wr_en;
    rf_wr_t                rf_wr;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;

    cpu_ctrl_fsm u_ctrl (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .instr_i     (rom_data),
        .ctrl_i      (ctrl),
        .csr_wdata_i (csr_wdata),
        .tx_byte_i   (tx_byte),
        .tx_ack_i    (tx_ack),
        .rom_addr_o  (rom_addr),
        .instr_o     (instr),
        .pc_o        (pc),
        .rf_wr_en_o  (rf_wr_en),
        .csr_o       (csr_o),
        .tx_o        (tx_hs)
    );

    exec_unit u_exec (
        .instr_i     (instr),
        .pc_i        (pc),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rf_wr_o     (rf_wr),
        .rf_wr_en_i  (rf_wr_en),
        .ctrl_o      (ctrl),
        .csr_wdata_o (csr_wdata),
        .tx_byte_o   (tx_byte)
    );

    reg_file u_rf (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (rf_wr)
    );

    bios_rom u_rom (
        .clk    (clk),
        .addr_i (rom_addr),
        .data_o (rom_data)
    );

    uart_tx u_uart (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hs_i     (tx_hs),
        .ack_o    (tx_ack),
        .serial_o (serial_tx_o)
    );

endmodule

/* verif/riscv151_chk.sv */
`timescale 1ns/1ps

module riscv151_chk import cpu_pkg::*; (
    input logic        clk,
    input logic        arst_n_i,
    input logic        serial_tx_i,
    input logic [31:0] csr_i,
    input logic        req_i,
    input logic        ack_i,
    input cpu_state_e  state_i
);

    int unsigned fail_cnt = 0;   // read by the testbench at the end

    // line idle and csr cleared while reset is held
    a_reset_idle: assert property (@(posedge clk)
        !arst_n_i |-> serial_tx_i && csr_i == 32'd0)
        else begin
            $error("serial line or csr not idle during reset");
            fail_cnt++;
        end

    a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_i && !ack_i |=> req_i)
        else begin
            $error("uart req dropped before ack");
            fail_cnt++;
        end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(ack_i) |-> req_i)
        else begin
            $error("uart ack rose with no req");
            fail_cnt++;
        end

    // the program only ever writes 10+9+...+1
    a_csr_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$stable(csr_i) |-> csr_i == 32'd55)
        else begin
            $error("csr changed to an unexpected value");
            fail_cnt++;
        end

    a_exec_next: assert property (@(posedge clk) disable iff (!arst_n_i)
        state_i == ST_EXEC |=> state_i inside {ST_FETCH, ST_IO_REQ})
        else begin
            $error("control fsm left exec for an illegal state");
            fail_cnt++;
        end

endmodule

/* verif/tb_riscv151.sv */
`timescale 1ns/1ps

module tb_riscv151 import cpu_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 2000;   // cycles per wait loop
    localparam int HALT_CYCLES  = 400;

    logic        clk;
    logic        arst_n_i;
    logic        serial_tx_o;
    logic [31:0] csr_o;

    int errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    riscv151 dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .serial_tx_o (serial_tx_o),
        .csr_o       (csr_o)
    );

    bind riscv151 riscv151_chk chk (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .serial_tx_i (serial_tx_o),
        .csr_i       (csr_o),
        .req_i       (tx_hs.req),
        .ack_i       (tx_ack),
        .state_i     (u_ctrl.state_q)
    );

    always #5 clk = ~clk;

    // sum of n down to 1, what the bios loop accumulates
    function automatic logic [31:0] loop_sum(input int n);
        logic [31:0] s;
        s = '0;
        for (int k = n; k > 0; k--)
            s += 32'(k);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic close_test(input string label, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", label, errors - errs_before);
        end else begin
            $display("test %s: ok", label);
        end
    endtask

    task automatic wait_start_bit(output bit found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (serial_tx_o === 1'b0)
                found = 1'b1;
            n++;
        end
        if (!found) begin
            $display("timeout: no start bit on serial_tx_o within %0d cycles", WAIT_LIMIT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = errors;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("serial_tx_o", 32'd1, 32'(serial_tx_o));
            check_value("csr_o", 32'd0, csr_o);
            @(posedge clk);
        end
        #1 arst_n_i = 1'b1;
        @(negedge clk);         // still idle just after release
        check_value("serial_tx_o", 32'd1, 32'(serial_tx_o));
        check_value("csr_o", 32'd0, csr_o);
        close_test("reset", errs_before);
    endtask

    task automatic check_sum();
        int errs_before;
        int n;
        bit done;
        errs_before = errors;
        n = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (csr_o !== 32'd0) begin
                done = 1'b1;
            end else if (serial_tx_o !== 1'b1) begin
                check_value("serial_tx_o", 32'd1, 32'(serial_tx_o));   // frame too early
                done = 1'b1;
            end
            n++;
        end
        if (!done) begin
            $display("timeout: csr_o never left zero within %0d cycles", WAIT_LIMIT);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value("csr_o", loop_sum(10), csr_o);
        end
        close_test("loop sum to csr", errs_before);
    endtask

    // samples each bit in its middle, start bit first
    task automatic receive_byte(input logic [7:0] expected, input string label);
        int errs_before;
        bit found;
        logic [7:0] rx;
        errs_before = errors;
        rx = '0;
        wait_start_bit(found);
        if (found) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
            check_value("serial_tx_o", 32'd0, 32'(serial_tx_o));
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx[i] = serial_tx_o;                   // lsb first
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value("serial_tx_o", 32'd1, 32'(serial_tx_o));   // stop bit
        end
        close_test({"frame ", label}, errs_before);
        errs_before = errors;
        if (found)
            check_value("serial_tx_o byte", 32'(expected), 32'(rx));
        close_test({"byte ", label}, errs_before);
    endtask

    task automatic check_halt();
        int errs_before;
        errs_before = errors;
        for (int i = 0; i < HALT_CYCLES + CLKS_PER_BIT; i++) begin
            @(negedge clk);
            if (errors == errs_before) begin
                check_value("serial_tx_o", 32'd1, 32'(serial_tx_o));
                check_value("csr_o", loop_sum(10), csr_o);
            end
        end
        close_test("halt", errs_before);
    endtask

    initial begin
        clk          = 1'b1;
        arst_n_i     = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        #1 arst_n_i = 1'b0;
        check_reset();
        if (!timed_out)
            check_sum();
        if (!timed_out)
            receive_byte(8'h4f, "O");
        if (!timed_out)
            receive_byte(8'h4b, "K");
        if (!timed_out)
            check_halt();
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut.chk.fail_cnt);
        if (errors == 0 && dut.chk.fail_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* bios.hex */
// one 32-bit instruction word per line, word 0 sits at 0x4000_0000
00000093
00a00113
002080b3
fff10113
fe011ce3
51e09073
800001b7
04f00213
0041a423
04b00213
0041a423
0000006f
00000013
00000013
00000013
00000013
00000013
00000013
00000013

/* vlog.f */
hw/cpu_pkg.sv
hw/baud_timer.sv
hw/uart_tx.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/cpu_ctrl_fsm.sv
hw/bios_rom.sv
hw/riscv151.sv
verif/riscv151_chk.sv
verif/tb_riscv151.sv
